/* src/wave_pkg.sv */
package wave_pkg;

	// ------------------------------------------------------------------------
	// sample and batch geometry
	// ------------------------------------------------------------------------
	localparam int sample_width = 16;
	localparam int batch_size   = 4;                        // samples per clock
	localparam int batch_width  = sample_width * batch_size;

	localparam int max_sample   = 32767;                    // top of the wave

	typedef logic [sample_width-1:0] sample_t;
	typedef logic [batch_width-1:0]  batch_t;               // lane 0 is earliest

	// ------------------------------------------------------------------------
	// waveform configuration
	// ------------------------------------------------------------------------
	typedef logic [7:0]  step_t;                            // triangle slope per sample
	typedef logic [11:0] half_period_t;                     // square half period, in batches
	typedef logic [2:0]  atten_t;                           // right shift on every lane

	localparam int default_step        = 1;
	localparam int default_half_period = 1;

endpackage

/* src/cmd_pkg.sv */
package cmd_pkg;

	// ------------------------------------------------------------------------
	// host command word
	// ------------------------------------------------------------------------
	localparam int cmd_width  = 32;
	localparam int opcode_msb = 31;
	localparam int opcode_lsb = 28;                     // payload sits in the low bits

	typedef logic [cmd_width-1:0] cmd_t;

	typedef enum logic [3:0] {
		op_sel_wave  = 4'd1,                            // payload 2 bits
		op_set_step  = 4'd2,                            // payload 8 bits
		op_set_half  = 4'd3,                            // payload 12 bits
		op_set_atten = 4'd4,                            // payload 3 bits
		op_run       = 4'd5,
		op_stop      = 4'd6
	} opcode_e;

	typedef enum logic [1:0] {
		wave_off = 2'd0,
		wave_tri = 2'd1,
		wave_sq  = 2'd2
	} wave_sel_e;

	localparam logic [1:0] wave_sel_invalid = 2'd3;

endpackage

/* src/wave_cmd_decode.sv */
`timescale 1ns/1ps

module wave_cmd_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmd_valid,
	input  cmd_pkg::cmd_t          cmd_word,
	output logic                   tri_run,
	output logic                   sq_run,
	output logic                   restart,
	output wave_pkg::step_t        step,
	output wave_pkg::half_period_t half_period,
	output wave_pkg::atten_t       atten,
	output logic                   cmd_err
);
	import wave_pkg::*;
	import cmd_pkg::*;

	opcode_e   opcode;
	wave_sel_e wave_sel;
	logic      run;

	assign opcode = opcode_e'(cmd_word[opcode_msb:opcode_lsb]);

	// only one generator ever sees run
	assign tri_run = run && (wave_sel == wave_tri);
	assign sq_run  = run && (wave_sel == wave_sq);

	// ------------------------------------------------------------------------
	// configuration registers, updated one command per strobe
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wave_sel    <= wave_off;
			step        <= step_t'(default_step);
			half_period <= half_period_t'(default_half_period);
			atten       <= '0;
			run         <= 1'b0;
			restart     <= 1'b0;
			cmd_err     <= 1'b0;
		end else begin
			restart <= 1'b0;                            // both are single-cycle pulses
			cmd_err <= 1'b0;
			if (cmd_valid) begin
				case (opcode)
					op_sel_wave: begin
						if (cmd_word[1:0] == wave_sel_invalid)
							cmd_err <= 1'b1;            // select 3 leaves wave_sel alone
						else
							wave_sel <= wave_sel_e'(cmd_word[1:0]);
					end
					op_set_step:  step        <= cmd_word[$bits(step_t)-1:0];
					op_set_half:  half_period <= cmd_word[$bits(half_period_t)-1:0];
					op_set_atten: atten       <= cmd_word[$bits(atten_t)-1:0];
					op_run: begin
						run     <= 1'b1;
						restart <= 1'b1;                // generators go back to phase 0
					end
					op_stop:      run         <= 1'b0;
					default:      cmd_err     <= 1'b1;
				endcase
			end
		end
	end

endmodule

/* src/trig_wave_gen.sv */
`timescale 1ns/1ps

module trig_wave_gen (
	input  logic             clk,
	input  logic             rst,
	input  logic             run,
	input  logic             restart,
	input  wave_pkg::step_t  step,
	output wave_pkg::batch_t batch,
	output logic             valid
);
	import wave_pkg::*;

	typedef enum logic {dir_rise, dir_fall} dir_e;
	typedef logic signed [sample_width+1:0] calc_t;     // room for over and under range

	dir_e    dir;
	dir_e    cur_dir;
	sample_t start;
	sample_t cur_start;
	calc_t   lane [batch_size];
	calc_t   next_start;
	batch_t  batch_comb;

	// ------------------------------------------------------------------------
	// lane values for the current batch
	// ------------------------------------------------------------------------
	always_comb begin
		cur_start = restart ? '0 : start;               // restart forces phase 0, rising
		cur_dir   = restart ? dir_rise : dir;
		for (int i = 0; i < batch_size; i++) begin
			if (cur_dir == dir_rise)
				lane[i] = calc_t'(cur_start) + calc_t'(i) * calc_t'(step);
			else
				lane[i] = calc_t'(cur_start) - calc_t'(i) * calc_t'(step);
			if (lane[i] < 0)
				batch_comb[i*sample_width +: sample_width] = '0;
			else if (lane[i] > calc_t'(max_sample))
				batch_comb[i*sample_width +: sample_width] = sample_t'(max_sample);
			else
				batch_comb[i*sample_width +: sample_width] = lane[i][sample_width-1:0];
		end
		if (cur_dir == dir_rise)
			next_start = calc_t'(cur_start) + calc_t'(batch_size) * calc_t'(step);
		else
			next_start = calc_t'(cur_start) - calc_t'(batch_size) * calc_t'(step);
	end

	// ------------------------------------------------------------------------
	// batch start and direction FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			start <= '0;
			dir   <= dir_rise;
			valid <= 1'b0;
		end else begin
			valid <= run;
			if (run) begin
				if (cur_dir == dir_rise && next_start > calc_t'(max_sample)) begin
					start <= sample_t'(max_sample);     // turn at the top
					dir   <= dir_fall;
				end else if (cur_dir == dir_fall && next_start < 0) begin
					start <= '0;                        // turn at the bottom
					dir   <= dir_rise;
				end else begin
					start <= next_start[sample_width-1:0];
					dir   <= cur_dir;
				end
			end else if (restart) begin
				start <= '0;
				dir   <= dir_rise;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (run)
			batch <= batch_comb;
	end

endmodule

/* src/square_wave_gen.sv */
`timescale 1ns/1ps

module square_wave_gen (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   run,
	input  logic                   restart,
	input  wave_pkg::half_period_t half_period,
	output wave_pkg::batch_t       batch,
	output logic                   valid
);
	import wave_pkg::*;

	logic                       level;
	logic                       cur_level;
	half_period_t               count;
	half_period_t               cur_count;
	half_period_t               hp_eff;
	logic [$bits(half_period_t):0] count_next;
	batch_t                     batch_comb;

	always_comb begin
		cur_level  = restart ? 1'b1 : level;            // first batch after restart is high
		cur_count  = restart ? '0 : count;
		hp_eff     = (half_period == '0) ? half_period_t'(1) : half_period;
		count_next = {1'b0, cur_count} + 1'b1;
		for (int i = 0; i < batch_size; i++)
			batch_comb[i*sample_width +: sample_width] = cur_level ? sample_t'(max_sample) : '0;
	end

	// ------------------------------------------------------------------------
	// batch counter and level toggle
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			level <= 1'b1;
			count <= '0;
			valid <= 1'b0;
		end else begin
			valid <= run;
			if (run) begin
				if (count_next >= {1'b0, hp_eff}) begin // also catches a shortened period
					level <= ~cur_level;
					count <= '0;
				end else begin
					level <= cur_level;
					count <= count_next[$bits(half_period_t)-1:0];
				end
			end else if (restart) begin
				level <= 1'b1;
				count <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (run)
			batch <= batch_comb;
	end

endmodule

/* src/batch_output_stage.sv */
`timescale 1ns/1ps

module batch_output_stage (
	input  logic             clk,
	input  logic             rst,
	input  wave_pkg::batch_t tri_batch,
	input  logic             tri_valid,
	input  wave_pkg::batch_t sq_batch,
	input  logic             sq_valid,
	input  wave_pkg::atten_t atten,
	output wave_pkg::batch_t batch_out,
	output logic             batch_valid
);
	import wave_pkg::*;

	logic   any_valid;
	batch_t sel_batch;
	batch_t shifted;

	assign any_valid = tri_valid | sq_valid;

	// ------------------------------------------------------------------------
	// select and attenuate per lane
	// ------------------------------------------------------------------------
	always_comb begin
		sel_batch = tri_valid ? tri_batch : sq_batch;   // valids never overlap
		for (int i = 0; i < batch_size; i++)
			shifted[i*sample_width +: sample_width] =
				sel_batch[i*sample_width +: sample_width] >> atten;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			batch_out   <= '0;
			batch_valid <= 1'b0;
		end else begin
			batch_valid <= any_valid;
			batch_out   <= any_valid ? shifted : '0;   // idle output reads as zero
		end
	end

endmodule

/* src/wave_batch_top.sv */
`timescale 1ns/1ps

module wave_batch_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             cmd_valid,
	input  cmd_pkg::cmd_t    cmd_word,
	output wave_pkg::batch_t batch_out,
	output logic             batch_valid,
	output logic             cmd_err
);
	import wave_pkg::*;

	logic         tri_run;
	logic         sq_run;
	logic         restart;
	step_t        step;
	half_period_t half_period;
	atten_t       atten;
	batch_t       tri_batch;
	logic         tri_valid;
	batch_t       sq_batch;
	logic         sq_valid;

	// ------------------------------------------------------------------------
	// command decode
	// ------------------------------------------------------------------------
	wave_cmd_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd_word    (cmd_word),
		.tri_run     (tri_run),
		.sq_run      (sq_run),
		.restart     (restart),
		.step        (step),
		.half_period (half_period),
		.atten       (atten),
		.cmd_err     (cmd_err)
	);

	// ------------------------------------------------------------------------
	// generators, one batch per cycle while running
	// ------------------------------------------------------------------------
	trig_wave_gen u_tri (
		.clk     (clk),
		.rst     (rst),
		.run     (tri_run),
		.restart (restart),
		.step    (step),
		.batch   (tri_batch),
		.valid   (tri_valid)
	);

	square_wave_gen u_sq (
		.clk         (clk),
		.rst         (rst),
		.run         (sq_run),
		.restart     (restart),
		.half_period (half_period),
		.batch       (sq_batch),
		.valid       (sq_valid)
	);

	batch_output_stage u_out (
		.clk         (clk),
		.rst         (rst),
		.tri_batch   (tri_batch),
		.tri_valid   (tri_valid),
		.sq_batch    (sq_batch),
		.sq_valid    (sq_valid),
		.atten       (atten),
		.batch_out   (batch_out),
		.batch_valid (batch_valid)
	);

endmodule

/* sim/wave_batch_props.sv */
`timescale 1ns/1ps

module wave_batch_props (
	input logic             clk,
	input logic             rst,
	input logic             cmd_valid,
	input cmd_pkg::cmd_t    cmd_word,
	input wave_pkg::batch_t batch_out,
	input logic             batch_valid,
	input logic             cmd_err
);
	import wave_pkg::*;
	import cmd_pkg::*;

	logic [3:0] opcode;
	logic       bad_cmd;
	logic       run_q;
	logic [1:0] sel_q;
	atten_t     atten_q;
	logic       idle;
	int         fail_count = 0;                     // read by the testbench

	assign opcode  = cmd_word[opcode_msb:opcode_lsb];
	assign bad_cmd = cmd_valid && (!(opcode inside {[op_sel_wave:op_stop]})
		|| (opcode == op_sel_wave && cmd_word[1:0] == wave_sel_invalid));
	assign idle    = !run_q || sel_q == wave_off;

	function automatic logic lanes_in_range(input batch_t b, input atten_t a);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < batch_size; i++)
			ok &= b[i*sample_width +: sample_width] <= (sample_t'(max_sample) >> a);
		return ok;
	endfunction

	// ------------------------------------------------------------------------
	// shadow of the decoder state, seen from the command port
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			run_q   <= 1'b0;
			sel_q   <= wave_off;
			atten_q <= '0;
		end else if (cmd_valid && !bad_cmd) begin
			case (opcode)
				op_sel_wave:  sel_q   <= cmd_word[1:0];
				op_set_atten: atten_q <= cmd_word[2:0];
				op_run:       run_q   <= 1'b1;
				op_stop:      run_q   <= 1'b0;
				default:      ;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// port properties
	// ------------------------------------------------------------------------
	a_err_pulse: assert property (@(posedge clk) disable iff (rst) bad_cmd |=> cmd_err)
		else begin
			$error("cmd_err missing after a rejected command");
			fail_count++;
		end
	a_err_cause: assert property (@(posedge clk) disable iff (rst) cmd_err |-> $past(bad_cmd))
		else begin
			$error("cmd_err raised without a rejected command");
			fail_count++;
		end
	a_idle_zero: assert property (@(posedge clk) disable iff (rst)
		!batch_valid |-> batch_out == '0)
		else begin
			$error("batch_out not zero while batch_valid is low");
			fail_count++;
		end
	a_in_range: assert property (@(posedge clk) disable iff (rst)
		batch_valid |-> lanes_in_range(batch_out, $past(atten_q)))   // shift of the edge before
		else begin
			$error("sample above the attenuated top of the wave");
			fail_count++;
		end
	a_run_latency: assert property (@(posedge clk) disable iff (rst)
		cmd_valid && opcode == op_run && (sel_q == wave_tri || sel_q == wave_sq)
		|-> ##3 batch_valid)
		else begin
			$error("batch_valid not high three cycles after run");
			fail_count++;
		end
	a_silent: assert property (@(posedge clk) disable iff (rst)
		idle && $past(idle) && $past(idle, 2) |-> !batch_valid)
		else begin
			$error("batch_valid while stopped or with no wave selected");
			fail_count++;
		end

endmodule

bind wave_batch_top wave_batch_props props0 (
	.clk         (clk),
	.rst         (rst),
	.cmd_valid   (cmd_valid),
	.cmd_word    (cmd_word),
	.batch_out   (batch_out),
	.batch_valid (batch_valid),
	.cmd_err     (cmd_err)
);

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;                         // 100 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* sim/tb_wave_batch.sv */
`timescale 1ns/1ps

module tb_wave_batch;
	import wave_pkg::*;
	import cmd_pkg::*;

	localparam int test_cycles    = 20 + 260 + 140 + 40 + 60 + 50;    // per test, rounded up
	localparam int timeout_cycles = test_cycles * 3 / 2;

	logic         clk;
	logic         rst;
	logic         cmd_valid;
	cmd_t         cmd_word;
	batch_t       batch_out;
	logic         batch_valid;
	logic         cmd_err;
	logic [31:0]  lfsr = 32'hcb08;
	logic [31:0]  rnd;
	sample_t      top;
	step_t        step_val;
	atten_t       atten_val;
	half_period_t hp_val;
	int           errors;
	int           test_errors;
	int           prop_fails;
	int           tests_run;
	int           tests_failed;
	int           cycle_count;

	tb_clock_gen clock0 (
		.clk (clk),
		.rst (rst)
	);

	wave_batch_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd_word    (cmd_word),
		.batch_out   (batch_out),
		.batch_valid (batch_valid),
		.cmd_err     (cmd_err)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(input int n);
		rnd = '0;
		repeat (n) begin
			lfsr = lfsr_step(lfsr);
			rnd  = {rnd[30:0], lfsr[0]};                // one step per bit
		end
	endtask

	function automatic sample_t lane(input int i);
		return batch_out[i*sample_width +: sample_width];
	endfunction

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_that(input logic ok, input string what);
		assert (ok) else begin
			$display("error: %s", what);
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		test_errors += dut0.props0.fail_count - prop_fails;    // bound assertion failures
		prop_fails   = dut0.props0.fail_count;
		tests_run++;
		if (test_errors == 0)
			$display("test %0d %s: ok", tests_run, name);
		else
			$display("test %0d %s: %0d errors", tests_run, name, test_errors);
		if (test_errors != 0)
			tests_failed++;
		errors += test_errors;
		test_errors = 0;
	endtask

	// returns at the edge that takes the command
	task automatic send_cmd(input logic [3:0] op, input logic [27:0] payload);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_word  <= {op, payload};
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	task automatic start_wave(input wave_sel_e sel, input logic [11:0] cfg, input atten_t a);
		send_cmd(op_stop, '0);
		send_cmd(op_sel_wave, 28'(sel));
		send_cmd(sel == wave_tri ? op_set_step : op_set_half, 28'(cfg));
		send_cmd(op_set_atten, 28'(a));
		send_cmd(op_run, '0);
		top = sample_t'(max_sample) >> a;
		repeat (3) @(negedge clk);                      // run latency
	endtask

	task automatic expect_err(input logic [3:0] op, input logic [27:0] payload);
		send_cmd(op, payload);
		@(negedge clk);
		check_eq("cmd_err", cmd_err, 1);
		@(negedge clk);
		check_eq("cmd_err", cmd_err, 0);
	endtask

	task automatic check_triangle(input int n, input int slope, input int min_turns);
		int   dir;
		int   last_dir;
		int   turns;
		int   diff;
		logic clamped;
		last_dir = 0;
		turns    = 0;
		repeat (n) begin
			check_eq("batch_valid", batch_valid, 1);
			clamped = 1'b0;
			for (int i = 0; i < batch_size; i++) begin
				check_that(lane(i) <= top, "triangle sample above the attenuated top");
				clamped |= (lane(i) == 0 || lane(i) == top);
			end
			for (int i = 1; i < batch_size; i++) begin
				diff = int'(lane(i)) - int'(lane(i-1));
				diff = diff < 0 ? -diff : diff;
				if (!clamped)
					check_that(diff >= slope - 1 && diff <= slope + 1,
						"triangle slope off by more than one count");
			end
			dir = lane(batch_size-1) > lane(0) ? 1 : (lane(batch_size-1) < lane(0) ? -1 : 0);
			if (dir != 0 && last_dir != 0 && dir != last_dir) begin
				turns++;
				check_that(lane(0) == (dir < 0 ? top : sample_t'(0)),
					"triangle turned away from the top or bottom");
			end
			if (dir != 0)
				last_dir = dir;
			@(negedge clk);
		end
		check_that(turns >= min_turns, "triangle did not reach both turns");
	endtask

	task automatic check_square(input int n, input int hp, input logic from_restart);
		int   run_len;
		logic level;
		logic known;
		run_len = 0;
		level   = 1'b1;
		known   = from_restart;                         // else the first run is partial
		if (from_restart)
			check_eq("batch_out lane 0", lane(0), top);
		repeat (n) begin
			check_eq("batch_valid", batch_valid, 1);
			for (int i = 1; i < batch_size; i++)
				check_eq("batch_out lane", lane(i), lane(0));
			check_that(lane(0) == top || lane(0) == 0, "square level neither high nor low");
			if (run_len > 0 && (lane(0) == top) != level) begin
				if (known)
					check_eq("square run length", run_len, hp);
				known   = 1'b1;
				run_len = 0;
			end
			level = lane(0) == top;
			run_len++;
			@(negedge clk);
		end
		check_that(run_len <= hp, "square level held longer than the half period");
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run did not end within %0d cycles", timeout_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		cmd_valid    = 1'b0;
		cmd_word     = '0;
		errors       = 0;
		test_errors  = 0;
		prop_fails   = 0;
		tests_run    = 0;
		tests_failed = 0;
		top          = sample_t'(max_sample);
		@(negedge clk);
		while (rst)
			@(negedge clk);

		// --------------------------------------------------------------------------
		// reset state, then latency with the default step
		// --------------------------------------------------------------------------
		check_eq("batch_valid", batch_valid, 0);
		check_eq("cmd_err", cmd_err, 0);
		check_eq("batch_out", batch_out, 0);
		send_cmd(op_sel_wave, 28'(wave_tri));
		send_cmd(op_run, '0);
		@(negedge clk);
		check_eq("batch_valid", batch_valid, 0);
		@(negedge clk);
		check_eq("batch_valid", batch_valid, 0);
		@(negedge clk);
		check_triangle(8, 1, 0);
		end_test("reset and run latency");

		start_wave(wave_tri, 12'd255, '0);
		check_triangle(80, 255, 2);                     // long enough for top and bottom
		repeat (3) begin
			draw(8);
			step_val = rnd[7:0];
			draw(3);
			atten_val = rnd[2:0];
			start_wave(wave_tri, 12'(step_val), atten_val);
			check_triangle(40, int'(step_val >> atten_val), 0);
		end
		end_test("triangle shape");

		repeat (2) begin
			draw(3);
			hp_val = half_period_t'(rnd[2:0]);
			draw(3);
			atten_val = rnd[2:0];
			start_wave(wave_sq, hp_val, atten_val);
			check_square(40, hp_val == 0 ? 1 : int'(hp_val), 1'b1);
		end
		end_test("square shape");

		// --------------------------------------------------------------------------
		// stop, then an empty selection
		// --------------------------------------------------------------------------
		send_cmd(op_stop, '0);
		@(negedge clk);
		check_eq("batch_valid", batch_valid, 1);
		@(negedge clk);
		check_eq("batch_valid", batch_valid, 1);
		@(negedge clk);
		check_eq("batch_valid", batch_valid, 0);
		check_eq("batch_out", batch_out, 0);
		start_wave(wave_off, 12'd1, '0);
		repeat (20) begin
			check_eq("batch_valid", batch_valid, 0);
			@(negedge clk);
		end
		end_test("stop and zeroing");

		start_wave(wave_sq, 12'd3, 3'd2);
		check_square(6, 3, 1'b1);
		expect_err(4'hf, '0);
		expect_err(4'h0, '0);
		expect_err(op_sel_wave, 28'd3);
		check_square(24, 3, 1'b0);                      // same wave, same half period
		end_test("command errors");

		start_wave(wave_tri, 12'd255, '0);
		repeat (8) @(negedge clk);
		draw(3);
		atten_val = rnd[2:0] | 3'd1;
		send_cmd(op_set_atten, 28'(atten_val));
		top = sample_t'(max_sample) >> atten_val;
		@(negedge clk);
		@(negedge clk);
		check_triangle(1, 255 >> atten_val, 0);         // next-but-one batch, new shift
		check_that(lane(0) != 0, "triangle phase restarted by the attenuation change");
		check_triangle(11, 255 >> atten_val, 0);
		end_test("attenuation change while running");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
src/wave_pkg.sv
src/cmd_pkg.sv
src/wave_cmd_decode.sv
src/trig_wave_gen.sv
src/square_wave_gen.sv
src/batch_output_stage.sv
src/wave_batch_top.sv
sim/wave_batch_props.sv
sim/tb_clock_gen.sv
sim/tb_wave_batch.sv

/* Makefile */
TOP = tb_wave_batch

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
